//--- rtl/core_defs.svh
// register-access core definitions
// address map, bus widths, identification words and
// job configuration reset values
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// bus widths
`define CTRL_ADDR_W      27
`define REG_DATA_W       32
`define REG_ADDR_W       14
`define BLOCK_SEL_W      2
`define BLOCK_OFFS_W     12
`define SRAM_DEPTH       256

// identification and unmapped answer
`define DEVICE_ID_VAL    32'h0000_4e43
`define DEVICE_REV_VAL   32'h0001_0002
`define UNMAPPED_RD_VAL  32'hdead_beef

// job configuration reset values
`define CFG_NUM_KEYS_RST           32'd65536
`define CFG_LOG_2_NUM_WORKERS_RST  32'd2
`define CFG_SHARD_ID_RST           32'd0
`define CFG_MAX_N_VALUES_RST       32'd16
`define CFG_FILTER_THRESHOLD_RST   32'd0
`define CFG_MAX_FPGA_PROCS_RST     4'd4
`define CFG_ALGO_SELECTION_RST     1'b0
`define CFG_PROC_BIT_MASK_RST      8'h0f

`endif

//--- rtl/core_pkg.sv
// shared types of the register-access core
// register bus request and response, block index,
// bridge states and the job configuration bundle
`include "core_defs.svh"

package core_pkg;

   // mirrors the read-not-write level of the register bus
   typedef enum logic {
      REG_WRITE = 1'b0,
      REG_READ  = 1'b1
   } reg_op_t;

   // block index, top two bits of the word address
   typedef enum logic [1:0] {
      BLK_DEVICE_ID  = 2'd0,
      BLK_JOB_CONFIG = 2'd1,
      BLK_SRAM       = 2'd2,
      BLK_UNMAPPED   = 2'd3
   } reg_block_t;

   typedef enum logic [1:0] {
      BR_IDLE       = 2'd0,
      BR_WRITE_WAIT = 2'd1,
      BR_READ_WAIT  = 2'd2
   } bridge_state_t;

   typedef struct packed {
      logic                    req;
      reg_op_t                 op;
      logic [`REG_ADDR_W-1:0]  addr;
      logic [`REG_DATA_W-1:0]  wr_data;
   } reg_req_t;

   typedef struct packed {
      logic                    ack;
      logic [`REG_DATA_W-1:0]  rd_data;
   } reg_rsp_t;

   // settings handed to the compute engine
   typedef struct packed {
      logic [31:0]  num_keys;
      logic [31:0]  log_2_num_workers;
      logic [31:0]  shard_id;
      logic [31:0]  max_n_values;
      logic [31:0]  filter_threshold;
      logic [3:0]   max_fpga_procs;
      logic         algo_selection;
      logic [7:0]   proc_bit_mask;
   } job_config_t;

endpackage

//--- rtl/control_port_bridge.sv
// host control port to register bus bridge
// captures single read/write strobes, issues one bus request,
// holds waitrequest until the ack and returns read data
`timescale 1ns/100ps
`include "core_defs.svh"

module control_port_bridge import core_pkg::*; (
   input  logic                      core_clk_int,
   input  logic                      reset,
   input  logic [`CTRL_ADDR_W-1:0]   control_port_address,
   input  logic                      control_port_read,
   input  logic                      control_port_write,
   input  logic [`REG_DATA_W-1:0]    control_port_writedata,
   output logic                      control_port_waitrequest,
   output logic                      control_port_read_datavalid,
   output logic [`REG_DATA_W-1:0]    control_port_readdata,
   output reg_req_t                  bus_req,
   input  reg_rsp_t                  bus_rsp,
   output logic                      addr_out_of_range
);

   bridge_state_t state;
   bridge_state_t state_next;
   logic strobe;
   logic req_pulse;
   logic rd_valid;
   reg_op_t req_op;
   logic [`REG_ADDR_W-1:0] req_addr;
   logic [`REG_DATA_W-1:0] req_wr_data;
   logic [`REG_DATA_W-1:0] rd_data_q;
   logic addr_oor_q;

   // new strobes only count while idle
   assign strobe = (state == BR_IDLE) && (control_port_read || control_port_write);

   //------------------------------
   // wait-request state machine
   //------------------------------
   always_comb begin
      state_next = state;
      case (state)
         BR_IDLE: begin
            // read wins if both strobes show up together
            if (control_port_read) begin
               state_next = BR_READ_WAIT;
            end else if (control_port_write) begin
               state_next = BR_WRITE_WAIT;
            end
         end
         BR_WRITE_WAIT, BR_READ_WAIT: begin
            if (bus_rsp.ack) begin
               state_next = BR_IDLE;
            end
         end
         default: begin
            state_next = BR_IDLE;
         end
      endcase
   end

   always_ff @(posedge core_clk_int) begin
      if (reset) begin
         state     <= BR_IDLE;
         req_pulse <= 1'b0;
         rd_valid  <= 1'b0;
      end else begin
         state     <= state_next;
         req_pulse <= strobe;
         rd_valid  <= (state == BR_READ_WAIT) && bus_rsp.ack;
      end
   end

   //------------------------------
   // request payload and read data
   //------------------------------
   always_ff @(posedge core_clk_int) begin
      if (strobe) begin
         req_op      <= control_port_read ? REG_READ : REG_WRITE;
         req_addr    <= control_port_address[`REG_ADDR_W-1:0];
         req_wr_data <= control_port_writedata;
         // upper host bits never reach a block
         addr_oor_q  <= |control_port_address[`CTRL_ADDR_W-1:`REG_ADDR_W];
      end
      if ((state == BR_READ_WAIT) && bus_rsp.ack) begin
         rd_data_q <= bus_rsp.rd_data;
      end
   end

   assign bus_req.req     = req_pulse;
   assign bus_req.op      = req_op;
   assign bus_req.addr    = req_addr;
   assign bus_req.wr_data = req_wr_data;
   assign addr_out_of_range = addr_oor_q;

   // high for the whole bus access, low the cycle after the ack
   assign control_port_waitrequest    = (state != BR_IDLE);
   assign control_port_read_datavalid = rd_valid;
   assign control_port_readdata       = rd_data_q;

endmodule

//--- rtl/reg_block_decoder.sv
// register block decoder
// routes each bus request to one block by the top address bits,
// muxes the responses and answers unmapped accesses itself
`timescale 1ns/100ps
`include "core_defs.svh"

module reg_block_decoder import core_pkg::*; (
   input  logic      core_clk_int,
   input  logic      reset,
   input  reg_req_t  bus_req,
   input  logic      addr_out_of_range,
   output reg_rsp_t  bus_rsp,
   output reg_req_t  id_req,
   output reg_req_t  cfg_req,
   output reg_req_t  sram_req,
   input  reg_rsp_t  id_rsp,
   input  reg_rsp_t  cfg_rsp,
   input  reg_rsp_t  sram_rsp
);

   reg_block_t blk;
   reg_req_t blk_req;
   logic unmapped_ack;

   //------------------------------
   // request side
   //------------------------------
   always_comb begin
      if (addr_out_of_range) begin
         blk = BLK_UNMAPPED;
      end else begin
         blk = reg_block_t'(bus_req.addr[`REG_ADDR_W-1 -: `BLOCK_SEL_W]);
      end
   end

   // blocks only see the offset inside their window
   always_comb begin
      blk_req      = bus_req;
      blk_req.req  = 1'b0;
      blk_req.addr = {{(`REG_ADDR_W - `BLOCK_OFFS_W){1'b0}}, bus_req.addr[`BLOCK_OFFS_W-1:0]};
   end

   always_comb begin
      id_req       = blk_req;
      id_req.req   = bus_req.req && (blk == BLK_DEVICE_ID);
      cfg_req      = blk_req;
      cfg_req.req  = bus_req.req && (blk == BLK_JOB_CONFIG);
      sram_req     = blk_req;
      sram_req.req = bus_req.req && (blk == BLK_SRAM);
   end

   // unmapped responder, same one-cycle latency as the blocks
   always_ff @(posedge core_clk_int) begin
      if (reset) begin
         unmapped_ack <= 1'b0;
      end else begin
         unmapped_ack <= bus_req.req && (blk == BLK_UNMAPPED);
      end
   end

   //------------------------------
   // response side
   //------------------------------
   always_comb begin
      bus_rsp.ack = id_rsp.ack | cfg_rsp.ack | sram_rsp.ack | unmapped_ack;
      if (id_rsp.ack) begin
         bus_rsp.rd_data = id_rsp.rd_data;
      end else if (cfg_rsp.ack) begin
         bus_rsp.rd_data = cfg_rsp.rd_data;
      end else if (sram_rsp.ack) begin
         bus_rsp.rd_data = sram_rsp.rd_data;
      end else if (unmapped_ack) begin
         bus_rsp.rd_data = `UNMAPPED_RD_VAL;
      end else begin
         bus_rsp.rd_data = '0;
      end
   end

endmodule

//--- rtl/device_id_regs.sv
// device identification block, read only
// offset 0 is the identifier, offset 1 the revision
`timescale 1ns/100ps
`include "core_defs.svh"

module device_id_regs import core_pkg::*; (
   input  logic      core_clk_int,
   input  logic      reset,
   input  reg_req_t  reg_req,
   output reg_rsp_t  reg_rsp
);

   logic ack;
   logic [`REG_DATA_W-1:0] rd_data;

   always_ff @(posedge core_clk_int) begin
      if (reset) begin
         ack <= 1'b0;
      end else begin
         // writes get acked too, nothing is stored
         ack <= reg_req.req;
      end
   end

   always_ff @(posedge core_clk_int) begin
      if (reg_req.req && (reg_req.op == REG_READ)) begin
         case (reg_req.addr)
            `REG_ADDR_W'(0): rd_data <= `DEVICE_ID_VAL;
            `REG_ADDR_W'(1): rd_data <= `DEVICE_REV_VAL;
            default:         rd_data <= '0;
         endcase
      end
   end

   assign reg_rsp.ack     = ack;
   assign reg_rsp.rd_data = rd_data;

endmodule

//--- rtl/job_config_regs.sv
// job configuration registers
// eight writable settings, each masked to its field width,
// driving the compute engine configuration outputs
`timescale 1ns/100ps
`include "core_defs.svh"

module job_config_regs import core_pkg::*; (
   input  logic         core_clk_int,
   input  logic         reset,
   input  reg_req_t     reg_req,
   output reg_rsp_t     reg_rsp,
   output job_config_t  job_config
);

   job_config_t cfg;
   logic [2:0] cfg_idx;
   logic cfg_hit;
   logic ack;
   logic [`REG_DATA_W-1:0] rd_mux;
   logic [`REG_DATA_W-1:0] rd_data;

   // offsets 0..7 only, everything above is a hole
   assign cfg_idx = reg_req.addr[2:0];
   assign cfg_hit = (reg_req.addr[`REG_ADDR_W-1:3] == '0);

   always_ff @(posedge core_clk_int) begin
      if (reset) begin
         ack                    <= 1'b0;
         cfg.num_keys           <= `CFG_NUM_KEYS_RST;
         cfg.log_2_num_workers  <= `CFG_LOG_2_NUM_WORKERS_RST;
         cfg.shard_id           <= `CFG_SHARD_ID_RST;
         cfg.max_n_values       <= `CFG_MAX_N_VALUES_RST;
         cfg.filter_threshold   <= `CFG_FILTER_THRESHOLD_RST;
         cfg.max_fpga_procs     <= `CFG_MAX_FPGA_PROCS_RST;
         cfg.algo_selection     <= `CFG_ALGO_SELECTION_RST;
         cfg.proc_bit_mask      <= `CFG_PROC_BIT_MASK_RST;
      end else begin
         ack <= reg_req.req;
         if (reg_req.req && (reg_req.op == REG_WRITE) && cfg_hit) begin
            case (cfg_idx)
               3'd0: cfg.num_keys          <= reg_req.wr_data;
               3'd1: cfg.log_2_num_workers <= reg_req.wr_data;
               3'd2: cfg.shard_id          <= reg_req.wr_data;
               3'd3: cfg.max_n_values      <= reg_req.wr_data;
               3'd4: cfg.filter_threshold  <= reg_req.wr_data;
               3'd5: cfg.max_fpga_procs    <= reg_req.wr_data[3:0];
               3'd6: cfg.algo_selection    <= reg_req.wr_data[0];
               3'd7: cfg.proc_bit_mask     <= reg_req.wr_data[7:0];
            endcase
         end
      end
   end

   // read mux, narrow fields zero-extended
   always_comb begin
      rd_mux = '0;
      if (cfg_hit) begin
         case (cfg_idx)
            3'd0: rd_mux = cfg.num_keys;
            3'd1: rd_mux = cfg.log_2_num_workers;
            3'd2: rd_mux = cfg.shard_id;
            3'd3: rd_mux = cfg.max_n_values;
            3'd4: rd_mux = cfg.filter_threshold;
            3'd5: rd_mux = {28'd0, cfg.max_fpga_procs};
            3'd6: rd_mux = {31'd0, cfg.algo_selection};
            3'd7: rd_mux = {24'd0, cfg.proc_bit_mask};
         endcase
      end
   end

   always_ff @(posedge core_clk_int) begin
      if (reg_req.req && (reg_req.op == REG_READ)) begin
         rd_data <= rd_mux;
      end
   end

   assign reg_rsp.ack     = ack;
   assign reg_rsp.rd_data = rd_data;
   assign job_config      = cfg;

endmodule

//--- rtl/sram_reg_port.sv
// on-chip word memory on the register bus
// registered read data, one-cycle ack for reads and writes
`timescale 1ns/100ps
`include "core_defs.svh"

module sram_reg_port import core_pkg::*; (
   input  logic      core_clk_int,
   input  logic      reset,
   input  reg_req_t  reg_req,
   output reg_rsp_t  reg_rsp
);

   logic [`REG_DATA_W-1:0] mem [`SRAM_DEPTH];
   logic [$clog2(`SRAM_DEPTH)-1:0] word_idx;
   logic ack;
   logic [`REG_DATA_W-1:0] rd_data;

   // low offset bits pick the word, upper offsets alias
   assign word_idx = reg_req.addr[$clog2(`SRAM_DEPTH)-1:0];

   //------------------------------
   // memory array
   //------------------------------
   always_ff @(posedge core_clk_int) begin
      if (reg_req.req && (reg_req.op == REG_WRITE)) begin
         mem[word_idx] <= reg_req.wr_data;
      end
      if (reg_req.req && (reg_req.op == REG_READ)) begin
         rd_data <= mem[word_idx];
      end
   end

   //------------------------------
   // ack logic
   //------------------------------
   always_ff @(posedge core_clk_int) begin
      if (reset) begin
         ack <= 1'b0;
      end else begin
         ack <= reg_req.req;
      end
   end

   assign reg_rsp.ack     = ack;
   assign reg_rsp.rd_data = rd_data;

endmodule

//--- rtl/core_top.sv
// register-access core top level
// host control port bridge, block decoder and the three
// register blocks, job configuration out to the compute engine
`timescale 1ns/100ps
`include "core_defs.svh"

module core_top import core_pkg::*; (
   input  logic                      core_clk_int,
   input  logic                      reset,
   input  logic [`CTRL_ADDR_W-1:0]   control_port_address,
   input  logic                      control_port_read,
   input  logic                      control_port_write,
   input  logic [`REG_DATA_W-1:0]    control_port_writedata,
   output logic                      control_port_waitrequest,
   output logic                      control_port_read_datavalid,
   output logic [`REG_DATA_W-1:0]    control_port_readdata,
   output job_config_t               job_config
);

   reg_req_t bus_req;
   reg_rsp_t bus_rsp;
   logic addr_out_of_range;
   reg_req_t id_req;
   reg_req_t cfg_req;
   reg_req_t sram_req;
   reg_rsp_t id_rsp;
   reg_rsp_t cfg_rsp;
   reg_rsp_t sram_rsp;

   control_port_bridge control_port_bridge_inst (
      .core_clk_int                (core_clk_int),
      .reset                       (reset),
      .control_port_address        (control_port_address),
      .control_port_read           (control_port_read),
      .control_port_write          (control_port_write),
      .control_port_writedata      (control_port_writedata),
      .control_port_waitrequest    (control_port_waitrequest),
      .control_port_read_datavalid (control_port_read_datavalid),
      .control_port_readdata       (control_port_readdata),
      .bus_req                     (bus_req),
      .bus_rsp                     (bus_rsp),
      .addr_out_of_range           (addr_out_of_range)
   );

   reg_block_decoder reg_block_decoder_inst (
      .core_clk_int      (core_clk_int),
      .reset             (reset),
      .bus_req           (bus_req),
      .addr_out_of_range (addr_out_of_range),
      .bus_rsp           (bus_rsp),
      .id_req            (id_req),
      .cfg_req           (cfg_req),
      .sram_req          (sram_req),
      .id_rsp            (id_rsp),
      .cfg_rsp           (cfg_rsp),
      .sram_rsp          (sram_rsp)
   );

   //------------------------------
   // register blocks
   //------------------------------
   device_id_regs device_id_regs_inst (
      .core_clk_int (core_clk_int),
      .reset        (reset),
      .reg_req      (id_req),
      .reg_rsp      (id_rsp)
   );

   job_config_regs job_config_regs_inst (
      .core_clk_int (core_clk_int),
      .reset        (reset),
      .reg_req      (cfg_req),
      .reg_rsp      (cfg_rsp),
      .job_config   (job_config)
   );

   sram_reg_port sram_reg_port_inst (
      .core_clk_int (core_clk_int),
      .reset        (reset),
      .reg_req      (sram_req),
      .reg_rsp      (sram_rsp)
   );

endmodule

//--- dv/core_chk.sv
// control port bridge checker
// concurrent assertions on reset state, read data and the bus ack
`timescale 1ns/100ps

module core_chk import core_pkg::*; (
   input logic      core_clk_int,
   input logic      reset,
   input logic      control_port_read,
   input logic      control_port_waitrequest,
   input logic      control_port_read_datavalid,
   input reg_req_t  bus_req,
   input reg_rsp_t  bus_rsp
);

   // outputs come out of reset quiet
   reset_quiet_a: assert property (@(posedge core_clk_int)
      reset |=> (!control_port_waitrequest && !control_port_read_datavalid))
      else $error("waitrequest or datavalid high in the cycle after reset");

   // read strobe three cycles earlier
   datavalid_after_read_a: assert property (@(posedge core_clk_int) disable iff (reset)
      control_port_read_datavalid |-> $past(control_port_read, 3))
      else $error("datavalid without a read strobe three cycles before");

   bus_ack_a: assert property (@(posedge core_clk_int) disable iff (reset)
      bus_req.req |=> bus_rsp.ack)
      else $error("register bus request not acked in the next cycle");

endmodule

bind control_port_bridge core_chk core_chk_inst (
   .core_clk_int                (core_clk_int),
   .reset                       (reset),
   .control_port_read           (control_port_read),
   .control_port_waitrequest    (control_port_waitrequest),
   .control_port_read_datavalid (control_port_read_datavalid),
   .bus_req                     (bus_req),
   .bus_rsp                     (bus_rsp)
);

//--- dv/core_tb.sv
// testbench for the register-access core
// drives host reads and writes through the control port,
// checks read data, read latency and the job configuration outputs
`timescale 1ns/100ps
`include "core_defs.svh"

module core_tb import core_pkg::*; ();

   localparam int WAIT_LIMIT = 20;

   logic                     core_clk_int = 1'b0;
   logic                     reset;
   logic [`CTRL_ADDR_W-1:0]  control_port_address;
   logic                     control_port_read;
   logic                     control_port_write;
   logic [`REG_DATA_W-1:0]   control_port_writedata;
   logic                     control_port_waitrequest;
   logic                     control_port_read_datavalid;
   logic [`REG_DATA_W-1:0]   control_port_readdata;
   job_config_t              job_config;

   // reference model state
   logic [31:0] lcg_state;
   logic [31:0] cfg_model [8];
   logic [31:0] mem_model [`SRAM_DEPTH];
   logic [31:0] exp_read;
   string       exp_name;

   int check_count;
   int error_count;
   int timeout_count;
   int reads_issued;
   int read_count;
   int read_error_count;

   core_top core_top_inst (
      .core_clk_int                (core_clk_int),
      .reset                       (reset),
      .control_port_address        (control_port_address),
      .control_port_read           (control_port_read),
      .control_port_write          (control_port_write),
      .control_port_writedata      (control_port_writedata),
      .control_port_waitrequest    (control_port_waitrequest),
      .control_port_read_datavalid (control_port_read_datavalid),
      .control_port_readdata       (control_port_readdata),
      .job_config                  (job_config)
   );

   always #10 core_clk_int = ~core_clk_int;

   //------------------------------
   // reference model
   //------------------------------
   function automatic logic [31:0] next_rand();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   // width of each configuration field, by offset
   function automatic logic [31:0] field_mask(input int idx);
      case (idx)
         5: return 32'h0000_000f;
         6: return 32'h0000_0001;
         7: return 32'h0000_00ff;
         default: return 32'hffff_ffff;
      endcase
   endfunction

   function automatic logic [`CTRL_ADDR_W-1:0] block_addr(input logic [1:0] blk, input int offs);
      return {13'd0, blk, offs[11:0]};
   endfunction

   function automatic logic [31:0] expected_read(input logic [`CTRL_ADDR_W-1:0] addr);
      logic [11:0] offs;
      offs = addr[11:0];
      if (addr[`CTRL_ADDR_W-1:`REG_ADDR_W] != '0) begin
         return `UNMAPPED_RD_VAL;
      end
      case (addr[13:12])
         2'd0: begin
            if (offs == 12'd0) begin
               return `DEVICE_ID_VAL;
            end else if (offs == 12'd1) begin
               return `DEVICE_REV_VAL;
            end
            return 32'd0;
         end
         2'd1: begin
            if (offs < 12'd8) begin
               return cfg_model[offs[2:0]];
            end
            return 32'd0;
         end
         2'd2: return mem_model[offs[7:0]];
         default: return `UNMAPPED_RD_VAL;
      endcase
   endfunction

   // only mapped configuration and memory words change
   function automatic void model_write(input logic [`CTRL_ADDR_W-1:0] addr,
                                       input logic [31:0] data);
      if (addr[`CTRL_ADDR_W-1:`REG_ADDR_W] == '0) begin
         if ((addr[13:12] == 2'd1) && (addr[11:0] < 12'd8)) begin
            cfg_model[addr[2:0]] = data & field_mask(int'(addr[2:0]));
         end else if (addr[13:12] == 2'd2) begin
            mem_model[addr[7:0]] = data;
         end
      end
   endfunction

   //------------------------------
   // checks
   //------------------------------
   function automatic bit value_differs(input string name, input logic [31:0] exp,
                                        input logic [31:0] act);
      if (act !== exp) begin
         $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
         return 1'b1;
      end
      return 1'b0;
   endfunction

   task automatic check_value(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
      check_count++;
      if (value_differs(name, exp, act)) begin
         error_count++;
      end
   endtask

   task automatic check_config(input string name);
      check_value({name, " num_keys"}, cfg_model[0], job_config.num_keys);
      check_value({name, " log_2_num_workers"}, cfg_model[1], job_config.log_2_num_workers);
      check_value({name, " shard_id"}, cfg_model[2], job_config.shard_id);
      check_value({name, " max_n_values"}, cfg_model[3], job_config.max_n_values);
      check_value({name, " filter_threshold"}, cfg_model[4], job_config.filter_threshold);
      check_value({name, " max_fpga_procs"}, cfg_model[5], {28'd0, job_config.max_fpga_procs});
      check_value({name, " algo_selection"}, cfg_model[6], {31'd0, job_config.algo_selection});
      check_value({name, " proc_bit_mask"}, cfg_model[7], {24'd0, job_config.proc_bit_mask});
   endtask

   // read data compare, one read outstanding at a time
   always @(negedge core_clk_int) begin
      if (control_port_read_datavalid) begin
         read_count++;
         if (value_differs(exp_name, exp_read, control_port_readdata)) begin
            read_error_count++;
         end
      end
   end

   //------------------------------
   // host port tasks
   //------------------------------
   task automatic host_write(input logic [`CTRL_ADDR_W-1:0] addr, input logic [31:0] data);
      int cycles;
      model_write(addr, data);
      @(posedge core_clk_int);
      control_port_address   <= addr;
      control_port_writedata <= data;
      control_port_write     <= 1'b1;
      @(posedge core_clk_int);
      control_port_write <= 1'b0;
      cycles = 0;
      do begin
         @(negedge core_clk_int);
         cycles++;
      end while (control_port_waitrequest && (cycles < WAIT_LIMIT));
      if (control_port_waitrequest) begin
         timeout_count++;
         $display("ERROR: write to %h never dropped waitrequest", addr);
      end
   endtask

   task automatic host_read(input logic [`CTRL_ADDR_W-1:0] addr, input string name);
      int cycles;
      reads_issued++;
      @(posedge core_clk_int);
      // previous read beat is compared by now
      exp_read = expected_read(addr);
      exp_name = name;
      control_port_address <= addr;
      control_port_read    <= 1'b1;
      @(posedge core_clk_int);
      control_port_read <= 1'b0;
      cycles = 0;
      do begin
         @(negedge core_clk_int);
         cycles++;
         if (!control_port_read_datavalid && !control_port_waitrequest) begin
            error_count++;
            $display("ERROR: %s dropped waitrequest before its read data", name);
         end
      end while (!control_port_read_datavalid && (cycles < WAIT_LIMIT));
      if (!control_port_read_datavalid) begin
         timeout_count++;
         $display("ERROR: %s never returned read data", name);
      end else begin
         check_value({name, " latency"}, 32'd3, cycles);
         check_value({name, " waitrequest at datavalid"}, 32'd0,
                     {31'd0, control_port_waitrequest});
      end
   endtask

   //------------------------------
   // test sequence
   //------------------------------
   initial begin
      int idx;
      int pick;
      logic [7:0] sram_idx [16];
      logic [7:0] tmp;

      lcg_state              = 32'hcd6edcf2;
      check_count            = 0;
      error_count            = 0;
      timeout_count          = 0;
      reads_issued           = 0;
      read_count             = 0;
      read_error_count       = 0;
      reset                  = 1'b1;
      control_port_address   = '0;
      control_port_read      = 1'b0;
      control_port_write     = 1'b0;
      control_port_writedata = '0;
      cfg_model[0] = `CFG_NUM_KEYS_RST;
      cfg_model[1] = `CFG_LOG_2_NUM_WORKERS_RST;
      cfg_model[2] = `CFG_SHARD_ID_RST;
      cfg_model[3] = `CFG_MAX_N_VALUES_RST;
      cfg_model[4] = `CFG_FILTER_THRESHOLD_RST;
      cfg_model[5] = {28'd0, `CFG_MAX_FPGA_PROCS_RST};
      cfg_model[6] = {31'd0, `CFG_ALGO_SELECTION_RST};
      cfg_model[7] = {24'd0, `CFG_PROC_BIT_MASK_RST};

      repeat (10) @(posedge core_clk_int);
      reset <= 1'b0;
      @(negedge core_clk_int);
      check_value("reset waitrequest", 32'd0, {31'd0, control_port_waitrequest});
      check_value("reset datavalid", 32'd0, {31'd0, control_port_read_datavalid});
      check_config("reset config");

      // identification block, writes must not stick
      host_read(block_addr(2'd0, 0), "device id");
      host_read(block_addr(2'd0, 1), "device revision");
      host_write(block_addr(2'd0, 0), next_rand());
      host_write(block_addr(2'd0, 1), next_rand());
      host_read(block_addr(2'd0, 0), "device id after write");
      host_read(block_addr(2'd0, 1), "device revision after write");

      for (idx = 0; idx < 8; idx++) begin
         host_write(block_addr(2'd1, idx), next_rand());
      end
      for (idx = 0; idx < 8; idx++) begin
         host_read(block_addr(2'd1, idx), $sformatf("config offset %0d", idx));
      end
      host_read(block_addr(2'd1, 9), "config hole offset 9");
      check_config("config after writes");

      // distinct memory words, the first four written twice
      for (idx = 0; idx < 16; idx++) begin
         sram_idx[idx] = {idx[3:0], 4'(next_rand())};
         host_write(block_addr(2'd2, int'(sram_idx[idx])), next_rand());
      end
      for (idx = 0; idx < 4; idx++) begin
         host_write(block_addr(2'd2, int'(sram_idx[idx])), next_rand());
      end
      for (idx = 15; idx > 0; idx--) begin
         pick = int'(next_rand() % 32'(idx + 1));
         tmp = sram_idx[idx];
         sram_idx[idx] = sram_idx[pick];
         sram_idx[pick] = tmp;
      end
      for (idx = 0; idx < 16; idx++) begin
         host_read(block_addr(2'd2, int'(sram_idx[idx])),
                   $sformatf("memory word %0d", sram_idx[idx]));
      end

      // unmapped space
      host_read(block_addr(2'd3, 5), "block 3 read");
      host_read({13'h0001, 2'd1, 12'd0}, "upper bits config read");
      host_read({13'h1abc, 2'd2, 4'h0, sram_idx[0]}, "upper bits memory read");
      host_write(block_addr(2'd3, 0), next_rand());
      host_write({13'h0001, 2'd1, 12'd0}, next_rand());
      host_write({13'h1abc, 2'd2, 4'h0, sram_idx[0]}, next_rand());
      host_read(block_addr(2'd1, 0), "config offset 0 after unmapped write");
      host_read(block_addr(2'd2, int'(sram_idx[0])), "memory word after unmapped write");
      check_config("config after unmapped writes");

      repeat (5) @(posedge core_clk_int);
      if (read_count != reads_issued) begin
         error_count++;
         $display("ERROR: %0d reads issued but %0d read data beats seen",
                  reads_issued, read_count);
      end
      $display("checks %0d, read compares %0d, errors %0d, read errors %0d, timeouts %0d",
               check_count, read_count, error_count, read_error_count, timeout_count);
      if ((error_count == 0) && (read_error_count == 0) && (timeout_count == 0)) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

//--- files.f
+incdir+rtl
rtl/core_pkg.sv
rtl/control_port_bridge.sv
rtl/reg_block_decoder.sv
rtl/device_id_regs.sv
rtl/job_config_regs.sv
rtl/sram_reg_port.sv
rtl/core_top.sv
dv/core_chk.sv
dv/core_tb.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f files.f --top-module core_tb -Mdir obj_dir
	./obj_dir/Vcore_tb | tee sim.log
	grep -q "^TESTBENCH PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log
